// ==== rtl/mips_consts.svh ====
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// Datapath widths
`define MIPS_WORD_W      32      // Data and instruction width
`define MIPS_REG_ADDR_W  5       // Register index width
`define MIPS_WORD_BYTES  4       // Bytes per word, PC step

// Register file
`define MIPS_NUM_REGS    32      // Architectural registers, r0 tied to zero

// Memory depths in words
`define MIPS_IMEM_WORDS  64      // Instruction memory depth
`define MIPS_DMEM_WORDS  64      // Data memory depth

// Debug port
`define MIPS_DU_ADDR_W   8       // Debug data-memory byte address width

// Instruction fields
`define MIPS_OP_W        6       // Opcode and function field width
`define MIPS_IMM_W       16      // Immediate field width

// Special encodings
`define MIPS_HALT_OP     6'h3F   // HALT opcode, all ones

`endif

// ==== rtl/mips_pkg.sv ====
`include "mips_consts.svh"

package mips_pkg;

    typedef logic [`MIPS_WORD_W-1:0] word_t;         // One data word
    typedef logic [`MIPS_REG_ADDR_W-1:0] reg_addr_t; // Register index

    typedef enum logic [`MIPS_OP_W-1:0] {
        OP_RTYPE = 6'h00, OP_ADDI = 6'h08, OP_ANDI = 6'h0C, OP_ORI = 6'h0D,
        OP_LW = 6'h23, OP_SW = 6'h2B, OP_HALT = `MIPS_HALT_OP
    } opcode_e;

    typedef enum logic [`MIPS_OP_W-1:0] {
        FN_ADDU = 6'h21, FN_SUBU = 6'h23, FN_AND = 6'h24,
        FN_OR = 6'h25, FN_XOR = 6'h26, FN_SLT = 6'h2A
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND,
        ALU_OR, ALU_XOR, ALU_SLT
    } alu_op_e;

    typedef struct packed {
        logic  valid;     // Low for a bubble
        word_t instr;     // Fetched instruction
    } if_id_t;

    typedef struct packed {
        word_t     rs_val;     // Operand A from register read
        word_t     rt_val;     // Operand B / store data
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;         // Destination, rd or rt by format
        word_t     imm;        // Extended immediate
        logic      alu_src;    // Immediate as operand B
        alu_op_e   alu_op;
        logic      mem_read;
        logic      mem_write;
        logic      reg_write;
        logic      halt;
    } id_ex_t;

    typedef struct packed {
        word_t     alu_result;  // Result or memory address
        word_t     store_data;  // Forwarded rt value for SW
        reg_addr_t rd;
        logic      mem_read;
        logic      mem_write;
        logic      reg_write;
        logic      halt;
    } ex_mem_t;

    typedef struct packed {
        word_t     read_data;   // Load data
        word_t     alu_result;
        reg_addr_t rd;
        logic      mem_to_reg;  // Pick load data for write-back
        logic      reg_write;
        logic      halt;
    } mem_wb_t;

    typedef struct packed {
        logic      we;        // Register write enable
        reg_addr_t addr;
        word_t     data;
    } wb_port_t;

endpackage

// ==== rtl/fetch_stage.sv ====
`timescale 1ns/1ps
`include "mips_consts.svh"

module fetch_stage import mips_pkg::*; (
    input  logic   i_clk,
    input  logic   i_reset,
    input  logic   i_clk_en,          // Global stall when low
    input  logic   i_du_write_en,     // Debug write strobe
    input  word_t  i_du_inst_addr_wr, // Byte address, word aligned
    input  word_t  i_du_data,
    input  logic   i_fetch_hold,      // Load-use or halt stop from decode
    output if_id_t o_if_id
);
    localparam int OFS_W   = $clog2(`MIPS_WORD_BYTES); // Byte offset bits
    localparam int IMEM_AW = $clog2(`MIPS_IMEM_WORDS); // Word index bits

    word_t imem [`MIPS_IMEM_WORDS]; // Program storage
    word_t pc;                      // Byte address of next fetch
    word_t fetched;                 // Async read at PC

    assign fetched = imem[pc[OFS_W +: IMEM_AW]];

    // Debug loader, allowed in any cycle
    always_ff @(posedge i_clk) begin
        if (i_du_write_en) begin
            imem[i_du_inst_addr_wr[OFS_W +: IMEM_AW]] <= i_du_data;
        end
    end

    // PC and IF/ID register
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            pc      <= '0;        // Start of program
            o_if_id <= '0;        // Bubble
        end else if (i_clk_en && !i_fetch_hold) begin
            pc            <= pc + `MIPS_WORD_BYTES; // Next word
            o_if_id.valid <= 1'b1;
            o_if_id.instr <= fetched;
        end
        // Held: PC and IF/ID keep the stalled instruction
    end

endmodule

// ==== rtl/decode_stage.sv ====
`timescale 1ns/1ps
`include "mips_consts.svh"

module decode_stage import mips_pkg::*; (
    input  logic      i_clk,
    input  logic      i_reset,
    input  logic      i_clk_en,
    input  if_id_t    i_if_id,
    input  ex_mem_t   i_ex_mem,      // EX/MEM for early operand bypass
    input  wb_port_t  i_wb,          // Register write from MEM/WB
    input  reg_addr_t i_du_reg_addr, // Debug register select
    output id_ex_t    o_id_ex,
    output logic      o_fetch_hold,  // Hold PC and IF/ID
    output word_t     o_du_reg_data
);
    word_t                 regs [`MIPS_NUM_REGS]; // Register file
    logic [`MIPS_OP_W-1:0]  opcode;
    logic [`MIPS_OP_W-1:0]  funct;
    logic [`MIPS_IMM_W-1:0] imm;
    reg_addr_t             rs, rt, rd;
    word_t                 imm_sext, imm_zext;
    word_t                 rs_val, rt_val;
    id_ex_t                id_next;    // Decoded instruction
    logic                  load_use;   // Load in ID/EX feeds this instruction
    logic                  halt_stop;  // Sticky once HALT issues
    logic                  issue;      // Instruction moves into ID/EX

    // Register read with bypass from the newest producer
    function automatic word_t read_reg(reg_addr_t addr);
        word_t val;
        if (addr == '0) begin
            val = '0;                                    // r0 always zero
        end else if (i_ex_mem.reg_write && !i_ex_mem.mem_read &&
                     i_ex_mem.rd == addr) begin
            val = i_ex_mem.alu_result;                   // ALU result two ahead
        end else if (i_wb.we && i_wb.addr == addr) begin
            val = i_wb.data;                             // Same-cycle write
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    assign opcode   = i_if_id.instr[31:26];
    assign rs       = i_if_id.instr[25:21];
    assign rt       = i_if_id.instr[20:16];
    assign rd       = i_if_id.instr[15:11];
    assign funct    = i_if_id.instr[5:0];
    assign imm      = i_if_id.instr[15:0];
    assign imm_sext = {{(`MIPS_WORD_W-`MIPS_IMM_W){imm[`MIPS_IMM_W-1]}}, imm};
    assign imm_zext = {{(`MIPS_WORD_W-`MIPS_IMM_W){1'b0}}, imm};

    always_comb begin
        rs_val = read_reg(rs);
        rt_val = read_reg(rt);
    end

    // Control decode
    always_comb begin
        id_next        = '0;       // Unknown opcode acts as NOP
        id_next.rs_val = rs_val;
        id_next.rt_val = rt_val;
        id_next.rs     = rs;
        id_next.rt     = rt;
        id_next.imm    = imm_sext;
        case (opcode)
            OP_RTYPE: begin
                id_next.rd        = rd;
                id_next.reg_write = 1'b1;
                case (funct)
                    FN_ADDU: id_next.alu_op = ALU_ADD;
                    FN_SUBU: id_next.alu_op = ALU_SUB;
                    FN_AND:  id_next.alu_op = ALU_AND;
                    FN_OR:   id_next.alu_op = ALU_OR;
                    FN_XOR:  id_next.alu_op = ALU_XOR;
                    FN_SLT:  id_next.alu_op = ALU_SLT;
                    default: id_next.reg_write = 1'b0; // Unsupported funct
                endcase
            end
            OP_ADDI: begin
                id_next.rd        = rt;                  // I-type writes rt
                id_next.alu_src   = 1'b1;
                id_next.alu_op    = ALU_ADD;
                id_next.reg_write = 1'b1;
            end
            OP_ANDI: begin
                id_next.rd        = rt;
                id_next.alu_src   = 1'b1;
                id_next.alu_op    = ALU_AND;
                id_next.reg_write = 1'b1;
                id_next.imm       = imm_zext;            // Logical ops zero-extend
            end
            OP_ORI: begin
                id_next.rd        = rt;
                id_next.alu_src   = 1'b1;
                id_next.alu_op    = ALU_OR;
                id_next.reg_write = 1'b1;
                id_next.imm       = imm_zext;
            end
            OP_LW: begin
                id_next.rd        = rt;
                id_next.alu_src   = 1'b1;
                id_next.mem_read  = 1'b1;
                id_next.reg_write = 1'b1;
            end
            OP_SW: begin
                id_next.alu_src   = 1'b1;                // Address = base + offset
                id_next.mem_write = 1'b1;
            end
            OP_HALT: id_next.halt = 1'b1;
            default: ;
        endcase
    end

    // Hazards
    assign load_use = i_if_id.valid && o_id_ex.mem_read && o_id_ex.rd != '0 &&
                      (o_id_ex.rd == rs || o_id_ex.rd == rt);
    assign issue        = i_if_id.valid && !load_use && !halt_stop;
    assign o_fetch_hold = load_use || halt_stop;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_clk_en && i_wb.we && i_wb.addr != '0) begin
            regs[i_wb.addr] <= i_wb.data;       // r0 never written
        end
    end

    // ID/EX register and halt stop
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_id_ex   <= '0;
            halt_stop <= 1'b0;
        end else if (i_clk_en) begin
            o_id_ex <= issue ? id_next : '0;     // Bubble on stall or stop
            if (issue && id_next.halt) begin
                halt_stop <= 1'b1;               // Nothing behind HALT issues
            end
        end
    end

    assign o_du_reg_data = regs[i_du_reg_addr];

endmodule

// ==== rtl/execute_stage.sv ====
`timescale 1ns/1ps
`include "mips_consts.svh"

module execute_stage import mips_pkg::*; (
    input  logic     i_clk,
    input  logic     i_reset,
    input  logic     i_clk_en,
    input  id_ex_t   i_id_ex,
    input  wb_port_t i_wb,      // MEM/WB write-back, second forward source
    output ex_mem_t  o_ex_mem
);
    word_t op_a;    // Forwarded rs value
    word_t fwd_b;   // Forwarded rt value, also store data
    word_t op_b;    // ALU operand B
    word_t result;

    // EX/MEM first, then write-back, then the value read in decode
    function automatic word_t forward(reg_addr_t addr, word_t reg_val);
        word_t val;
        if (addr == '0) begin
            val = reg_val;                        // r0 never forwarded
        end else if (o_ex_mem.reg_write && !o_ex_mem.mem_read &&
                     o_ex_mem.rd == addr) begin
            val = o_ex_mem.alu_result;            // Loads held off by load-use stall
        end else if (i_wb.we && i_wb.addr == addr) begin
            val = i_wb.data;
        end else begin
            val = reg_val;
        end
        return val;
    endfunction

    always_comb begin
        op_a  = forward(i_id_ex.rs, i_id_ex.rs_val);
        fwd_b = forward(i_id_ex.rt, i_id_ex.rt_val);
    end

    assign op_b = i_id_ex.alu_src ? i_id_ex.imm : fwd_b;

    // ALU
    always_comb begin
        case (i_id_ex.alu_op)
            ALU_ADD: result = op_a + op_b;
            ALU_SUB: result = op_a - op_b;
            ALU_AND: result = op_a & op_b;
            ALU_OR:  result = op_a | op_b;
            ALU_XOR: result = op_a ^ op_b;
            ALU_SLT: result = {{(`MIPS_WORD_W-1){1'b0}},
                               $signed(op_a) < $signed(op_b)}; // Signed compare
            default: result = '0;
        endcase
    end

    // EX/MEM register
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_ex_mem <= '0;                       // Bubble
        end else if (i_clk_en) begin
            o_ex_mem.alu_result <= result;
            o_ex_mem.store_data <= fwd_b;
            o_ex_mem.rd         <= i_id_ex.rd;
            o_ex_mem.mem_read   <= i_id_ex.mem_read;
            o_ex_mem.mem_write  <= i_id_ex.mem_write;
            o_ex_mem.reg_write  <= i_id_ex.reg_write;
            o_ex_mem.halt       <= i_id_ex.halt;
        end
    end

endmodule

// ==== rtl/memory_stage.sv ====
`timescale 1ns/1ps
`include "mips_consts.svh"

module memory_stage import mips_pkg::*; (
    input  logic                       i_clk,
    input  logic                       i_reset,
    input  logic                       i_clk_en,
    input  ex_mem_t                    i_ex_mem,
    input  logic [`MIPS_DU_ADDR_W-1:0] i_du_mem_addr, // Debug byte address
    output wb_port_t                   o_wb,          // To regfile and forwarding
    output word_t                      o_du_mem_data,
    output logic                       o_halt         // Sticky end of program
);
    localparam int OFS_W   = $clog2(`MIPS_WORD_BYTES);
    localparam int DMEM_AW = $clog2(`MIPS_DMEM_WORDS);

    word_t   dmem [`MIPS_DMEM_WORDS]; // Data memory
    word_t   load_data;
    mem_wb_t mem_wb;                  // MEM/WB register

    assign load_data = dmem[i_ex_mem.alu_result[OFS_W +: DMEM_AW]];

    // Store lands on the edge that loads MEM/WB
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 0; i < `MIPS_DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (i_clk_en && i_ex_mem.mem_write) begin
            dmem[i_ex_mem.alu_result[OFS_W +: DMEM_AW]] <= i_ex_mem.store_data;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            mem_wb <= '0;
            o_halt <= 1'b0;
        end else if (i_clk_en) begin
            mem_wb.read_data  <= load_data;
            mem_wb.alu_result <= i_ex_mem.alu_result;
            mem_wb.rd         <= i_ex_mem.rd;
            mem_wb.mem_to_reg <= i_ex_mem.mem_read;
            mem_wb.reg_write  <= i_ex_mem.reg_write;
            mem_wb.halt       <= i_ex_mem.halt;
            if (mem_wb.halt) begin
                o_halt <= 1'b1;                   // HALT leaving MEM/WB
            end
        end
    end

    // Write-back select
    assign o_wb.we   = mem_wb.reg_write;
    assign o_wb.addr = mem_wb.rd;
    assign o_wb.data = mem_wb.mem_to_reg ? mem_wb.read_data : mem_wb.alu_result;

    assign o_du_mem_data = dmem[i_du_mem_addr[OFS_W +: DMEM_AW]];

endmodule

// ==== rtl/mips_pipeline.sv ====
`timescale 1ns/1ps
`include "mips_consts.svh"

module mips_pipeline import mips_pkg::*; (
    input  logic                       i_clk,
    input  logic                       i_reset,
    input  logic                       i_clk_en,          // Pauses the whole core
    input  logic                       i_du_write_en,     // Program load strobe
    input  word_t                      i_du_data,
    input  word_t                      i_du_inst_addr_wr,
    input  reg_addr_t                  i_du_reg_addr,
    input  logic [`MIPS_DU_ADDR_W-1:0] i_du_mem_addr,
    output logic                       o_du_halt,
    output word_t                      o_du_regs_mem_data,
    output word_t                      o_du_mem_data
);
    if_id_t   if_id;      // IF/ID
    id_ex_t   id_ex;      // ID/EX
    ex_mem_t  ex_mem;     // EX/MEM
    wb_port_t wb;         // Write-back port from MEM/WB
    logic     fetch_hold; // Load-use stall or halt stop

    fetch_stage u_fetch (
        .i_clk             (i_clk),
        .i_reset           (i_reset),
        .i_clk_en          (i_clk_en),
        .i_du_write_en     (i_du_write_en),
        .i_du_inst_addr_wr (i_du_inst_addr_wr),
        .i_du_data         (i_du_data),
        .i_fetch_hold      (fetch_hold),
        .o_if_id           (if_id)
    );

    decode_stage u_decode (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_clk_en      (i_clk_en),
        .i_if_id       (if_id),
        .i_ex_mem      (ex_mem),
        .i_wb          (wb),
        .i_du_reg_addr (i_du_reg_addr),
        .o_id_ex       (id_ex),
        .o_fetch_hold  (fetch_hold),
        .o_du_reg_data (o_du_regs_mem_data)
    );

    execute_stage u_execute (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_clk_en (i_clk_en),
        .i_id_ex  (id_ex),
        .i_wb     (wb),      // Second forward source
        .o_ex_mem (ex_mem)
    );

    memory_stage u_memory (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_clk_en      (i_clk_en),
        .i_ex_mem      (ex_mem),
        .i_du_mem_addr (i_du_mem_addr),
        .o_wb          (wb),
        .o_du_mem_data (o_du_mem_data),
        .o_halt        (o_du_halt)
    );

endmodule

// ==== bench/pipeline_tb.sv ====
`timescale 1ns/1ps
`include "mips_consts.svh"

module pipeline_tb import mips_pkg::*; ();
    localparam int  NUM_PROGS    = 12;
    localparam int  PROG_LEN     = 40;   // Instructions ahead of HALT
    localparam time CLK_PERIOD   = 100;
    localparam int  RESET_CYCLES = 4;
    localparam int  HOLD_CYCLES  = 20;   // Idle cycles checked after halt
    localparam int  PROG_CYCLES  = `MIPS_IMEM_WORDS + RESET_CYCLES   // Load under reset
                                 + PROG_LEN * 3                     // Run to halt
                                 + 2 * `MIPS_DMEM_WORDS + HOLD_CYCLES + 8; // Sweeps, hold

    logic                       i_clk, i_reset, i_clk_en, i_du_write_en;
    word_t                      i_du_data, i_du_inst_addr_wr;
    reg_addr_t                  i_du_reg_addr;
    logic [`MIPS_DU_ADDR_W-1:0] i_du_mem_addr;
    logic                       o_du_halt;
    word_t                      o_du_regs_mem_data, o_du_mem_data;

    word_t     prog [`MIPS_IMEM_WORDS];     // Program image, HALT at PROG_LEN
    word_t     exp_regs [`MIPS_NUM_REGS];   // Reference register file
    word_t     exp_mem [`MIPS_DMEM_WORDS];  // Reference data memory
    reg_addr_t last_dest;                   // Destination of previous instruction
    bit        pause_mode;                  // Random clock-enable gaps
    int        sweeps_req;
    int        sweeps_done;

    mips_pipeline DUT (.*);

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    initial begin
        #(NUM_PROGS * PROG_CYCLES * CLK_PERIOD);
        $display("TIMEOUT: o_du_halt never came or the run stalled after it");
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

    task automatic check_reg(input reg_addr_t addr, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: r%0d read %h, expected %h", $time, addr, got, exp);
            $display("tests failed");
            $fatal(1, "register mismatch");
        end
    endtask

    task automatic check_mem(input int idx, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: dmem[%0d] read %h, expected %h", $time, idx, got, exp);
            $display("tests failed");
            $fatal(1, "memory mismatch");
        end
    endtask

    task automatic check_halt(input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED at %0t: o_du_halt is %b, expected %b", $time, got, exp);
            $display("tests failed");
            $fatal(1, "halt flag mismatch");
        end
    endtask

    // Sequential ISA model, one instruction at a time from zeroed state
    function automatic void run_reference();
        word_t     instr, a, b, sext, zext, res, addr;
        reg_addr_t rs, rt, rd;
        int        pc;
        bit        done;
        foreach (exp_regs[i]) exp_regs[i] = '0;
        foreach (exp_mem[i]) exp_mem[i] = '0;
        pc   = 0;
        done = 1'b0;
        while (!done && pc < `MIPS_IMEM_WORDS) begin
            instr = prog[pc];
            pc++;
            rs    = instr[25:21];
            rt    = instr[20:16];
            rd    = instr[15:11];
            a     = exp_regs[rs];
            b     = exp_regs[rt];
            sext  = {{16{instr[15]}}, instr[15:0]};
            zext  = {16'h0000, instr[15:0]};
            addr  = a + sext;                       // Load/store byte address
            case (instr[31:26])
                OP_RTYPE: begin
                    case (instr[5:0])
                        FN_ADDU: res = a + b;
                        FN_SUBU: res = a - b;
                        FN_AND:  res = a & b;
                        FN_OR:   res = a | b;
                        FN_XOR:  res = a ^ b;
                        FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: res = '0;
                    endcase
                    if (rd != '0) exp_regs[rd] = res;
                end
                OP_ADDI: if (rt != '0) exp_regs[rt] = a + sext;
                OP_ANDI: if (rt != '0) exp_regs[rt] = a & zext;
                OP_ORI:  if (rt != '0) exp_regs[rt] = a | zext;
                OP_LW:   if (rt != '0) exp_regs[rt] = exp_mem[(addr >> 2) % `MIPS_DMEM_WORDS];
                OP_SW:   exp_mem[(addr >> 2) % `MIPS_DMEM_WORDS] = b;
                OP_HALT: done = 1'b1;                 // Nothing after HALT counts
                default: ;
            endcase
        end
    endfunction

    // Random instruction from the supported subset
    function automatic word_t gen_instr(input bit chain);
        int                     kind;
        reg_addr_t              rs, rt, rd;
        logic [`MIPS_IMM_W-1:0] imm;
        opcode_e                op;
        funct_e                 fn;
        word_t                  w;
        kind = $urandom % 11;
        rs   = reg_addr_t'($urandom % 8);           // Few registers, frequent hazards
        rt   = reg_addr_t'($urandom % 8);
        rd   = reg_addr_t'($urandom % 8);
        imm  = `MIPS_IMM_W'($urandom);
        if (chain) rs = last_dest;                  // Consume previous result at once
        case (kind)
            0: fn = FN_ADDU;
            1: fn = FN_SUBU;
            2: fn = FN_AND;
            3: fn = FN_OR;
            4: fn = FN_XOR;
            default: fn = FN_SLT;
        endcase
        case (kind)
            6: op = OP_ADDI;
            7: op = OP_ANDI;
            8: op = OP_ORI;
            9: op = OP_LW;
            10: op = OP_SW;
            default: op = OP_RTYPE;
        endcase
        if (op == OP_LW || op == OP_SW) begin
            if (chain && op == OP_SW) rt = last_dest; // Store the fresh value
            rs  = '0;                                 // Base r0
            imm = `MIPS_IMM_W'(($urandom % `MIPS_DMEM_WORDS) * `MIPS_WORD_BYTES);
        end
        if (op == OP_RTYPE) begin
            w = {op, rs, rt, rd, 5'd0, fn};
            last_dest = rd;
        end else begin
            w = {op, rs, rt, imm};
            if (op != OP_SW) last_dest = rt;
        end
        return w;
    endfunction

    task automatic load_program();
        @(negedge i_clk);
        i_reset  = 1'b1;
        i_clk_en = 1'b1;
        for (int k = 0; k < `MIPS_IMEM_WORDS; k++) begin
            i_du_write_en     = 1'b1;
            i_du_inst_addr_wr = word_t'(k * `MIPS_WORD_BYTES);
            i_du_data         = prog[k];
            @(negedge i_clk);
        end
        i_du_write_en = 1'b0;
        repeat (RESET_CYCLES) @(negedge i_clk);
        i_reset = 1'b0;
        check_halt(o_du_halt, 1'b0);
    endtask

    task automatic request_sweep();
        sweeps_req++;
        wait (sweeps_done == sweeps_req);
    endtask

    // Compare process, reads every register and data word after halt
    initial begin
        i_du_reg_addr = '0;
        i_du_mem_addr = '0;
        forever begin
            wait (sweeps_done < sweeps_req);
            for (int i = 0; i < `MIPS_DMEM_WORDS; i++) begin
                @(negedge i_clk);
                i_du_mem_addr = `MIPS_DU_ADDR_W'(i * `MIPS_WORD_BYTES);
                if (i < `MIPS_NUM_REGS) i_du_reg_addr = reg_addr_t'(i);
                #(CLK_PERIOD / 4);                  // Mid low phase, reads settled
                if (i < `MIPS_NUM_REGS) begin
                    check_reg(reg_addr_t'(i), o_du_regs_mem_data, exp_regs[i]);
                end
                check_mem(i, o_du_mem_data, exp_mem[i]);
            end
            sweeps_done++;
        end
    end

    initial begin
        void'($urandom(40761));
        i_reset           = 1'b1;
        i_clk_en          = 1'b0;
        i_du_write_en     = 1'b0;
        i_du_data         = '0;
        i_du_inst_addr_wr = '0;
        for (int p = 0; p < NUM_PROGS; p++) begin
            pause_mode = p[1];
            last_dest  = '0;
            for (int k = 0; k < `MIPS_IMEM_WORDS; k++) begin
                if (k == PROG_LEN) prog[k] = {`MIPS_HALT_OP, 26'd0};
                else prog[k] = gen_instr(p[0]); // Words past HALT must stay dead
            end
            run_reference();
            load_program();
            while (o_du_halt !== 1'b1) begin
                @(negedge i_clk);
                i_clk_en = pause_mode ? ($urandom % 4 != 0) : 1'b1;
            end
            i_clk_en = 1'b1;
            request_sweep();
            repeat (HOLD_CYCLES) begin
                @(negedge i_clk);
                i_clk_en = ($urandom % 2 != 0);
                check_halt(o_du_halt, 1'b1);         // Sticky until reset
            end
            i_clk_en = 1'b1;
            request_sweep();                          // State frozen after halt
        end
        $display("all tests passed");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+rtl
rtl/mips_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/mips_pipeline.sv
bench/pipeline_tb.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing -f build.f --top-module pipeline_tb -o pipeline_sim \
    && ./obj_dir/pipeline_sim \
    || { echo "simulation did not pass"; exit 1; }
